// File: include/rv_defines.svh
/* core-wide sizing macros: data width, register count and index width, reset address */

`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data path and address width
`define RV_XLEN 32

// integer register file
`define RV_REG_COUNT 32
`define RV_REG_AW 5

// first fetch address after reset
`define RV_RESET_PC 32'h8000_0000

`endif

// File: rtl/rv_isa_pkg.sv
/* instruction encoding types: major opcodes, instruction formats, branch conditions */

package rv_isa_pkg;

    // major opcodes kept by the core, inst[6:0]
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,  // register-register alu
        opc_op_imm = 7'b0010011,  // register-immediate alu
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011
    } opcode_e;

    // immediate layout of the instruction
    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_b,
        fmt_u,
        fmt_j,
        fmt_none  // unknown opcode, no immediate
    } inst_fmt_e;

    // branch funct3 codes
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } branch_cond_e;

endpackage

// File: rtl/rv_ctrl_pkg.sv
/* internal control types: alu operation and write-back source */

package rv_ctrl_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,   // signed compare
        alu_sltu,  // unsigned compare
        alu_xor,
        alu_srl,
        alu_sra,   // sign-filling shift
        alu_or,
        alu_and
    } alu_op_e;

    // what goes to rd at the end of the cycle
    typedef enum logic [1:0] {
        wb_none,  // branches and unknown opcodes
        wb_alu,
        wb_link   // pc + 4 for jal/jalr
    } wb_src_e;

endpackage

// File: rtl/inst_decoder.sv
/* instruction decoder: field split, format and immediate, alu op and write-back control */
`timescale 1ns/1ns
`include "rv_defines.svh"

module inst_decoder (
    input  logic [`RV_XLEN-1:0]     inst,
    output rv_isa_pkg::opcode_e      opcode,
    output logic [`RV_REG_AW-1:0]   rs1,
    output logic [`RV_REG_AW-1:0]   rs2,
    output logic [`RV_REG_AW-1:0]   rd,
    output logic [`RV_XLEN-1:0]     imm,
    output rv_ctrl_pkg::alu_op_e     alu_op,
    output rv_isa_pkg::branch_cond_e branch_cond,
    output rv_ctrl_pkg::wb_src_e     wb_src
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    inst_fmt_e  fmt;

    assign opcode      = opcode_e'(inst[6:0]);  // unkept codes fall to defaults below
    assign rd          = inst[11:7];
    assign funct3      = inst[14:12];
    assign rs1         = inst[19:15];
    assign rs2         = inst[24:20];
    assign funct7      = inst[31:25];
    assign branch_cond = branch_cond_e'(funct3);

    always_comb begin
        case (opcode)
            opc_op:               fmt = fmt_r;
            opc_op_imm, opc_jalr: fmt = fmt_i;
            opc_branch:           fmt = fmt_b;
            opc_lui, opc_auipc:   fmt = fmt_u;
            opc_jal:              fmt = fmt_j;
            default:              fmt = fmt_none;
        endcase
    end

    always_comb begin
        case (fmt)
            fmt_i:   imm = {{20{inst[31]}}, inst[31:20]};
            fmt_b:   imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            fmt_u:   imm = {inst[31:12], 12'b0};  // upper 20 bits, low bits zero
            fmt_j:   imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    // everything that is not op/op_imm uses the adder
    always_comb begin
        alu_op = alu_add;
        if (opcode == opc_op || opcode == opc_op_imm) begin
            case (funct3)
                3'b000:  alu_op = (fmt == fmt_r && funct7[5]) ? alu_sub : alu_add;
                3'b001:  alu_op = alu_sll;
                3'b010:  alu_op = alu_slt;
                3'b011:  alu_op = alu_sltu;
                3'b100:  alu_op = alu_xor;
                3'b101:  alu_op = funct7[5] ? alu_sra : alu_srl;  // also for srai
                3'b110:  alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

    always_comb begin
        case (opcode)
            opc_op, opc_op_imm, opc_lui, opc_auipc: wb_src = wb_alu;
            opc_jal, opc_jalr:                      wb_src = wb_link;
            default:                                wb_src = wb_none;
        endcase
    end

endmodule

// File: rtl/reg_file.sv
/* integer register file, two async read ports and one write port */
`timescale 1ns/1ns
`include "rv_defines.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  logic [`RV_REG_AW-1:0] waddr,
    input  logic [`RV_XLEN-1:0]   wdata,
    input  logic [`RV_REG_AW-1:0] raddr1,
    input  logic [`RV_REG_AW-1:0] raddr2,
    output logic [`RV_XLEN-1:0]   rdata1,
    output logic [`RV_XLEN-1:0]   rdata2
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin  // x0 never written
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: rtl/alu_exec.sv
/* operand selection and the integer alu */
`timescale 1ns/1ns
`include "rv_defines.svh"

module alu_exec (
    input  rv_isa_pkg::opcode_e  opcode,
    input  rv_ctrl_pkg::alu_op_e alu_op,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] rs1_data,
    input  logic [`RV_XLEN-1:0] rs2_data,
    input  logic [`RV_XLEN-1:0] imm,
    output logic [`RV_XLEN-1:0] alu_result
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [4:0]          shamt;

    always_comb begin
        case (opcode)
            opc_lui:                      op_a = '0;  // result is just the immediate
            opc_auipc, opc_jal, opc_branch: op_a = pc;  // pc-relative targets
            default:                      op_a = rs1_data;
        endcase
    end

    assign op_b  = (opcode == opc_op) ? rs2_data : imm;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            alu_add:  alu_result = op_a + op_b;
            alu_sub:  alu_result = op_a - op_b;
            alu_sll:  alu_result = op_a << shamt;
            alu_slt:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_result = {31'b0, op_a < op_b};
            alu_xor:  alu_result = op_a ^ op_b;
            alu_srl:  alu_result = op_a >> shamt;
            alu_sra:  alu_result = $unsigned($signed(op_a) >>> shamt);
            alu_or:   alu_result = op_a | op_b;
            alu_and:  alu_result = op_a & op_b;
            default:  alu_result = op_a + op_b;
        endcase
    end

endmodule

// File: rtl/branch_resolve.sv
/* branch compare, jump decision and redirect target */
`timescale 1ns/1ns
`include "rv_defines.svh"

module branch_resolve (
    input  rv_isa_pkg::opcode_e      opcode,
    input  rv_isa_pkg::branch_cond_e branch_cond,
    input  logic [`RV_XLEN-1:0]     rs1_data,
    input  logic [`RV_XLEN-1:0]     rs2_data,
    input  logic [`RV_XLEN-1:0]     alu_result,
    output logic                    jump_en,
    output logic [`RV_XLEN-1:0]     jump_target
);
    import rv_isa_pkg::*;

    logic cond_true;

    always_comb begin
        case (branch_cond)
            br_beq:  cond_true = (rs1_data == rs2_data);
            br_bne:  cond_true = (rs1_data != rs2_data);
            br_blt:  cond_true = ($signed(rs1_data) < $signed(rs2_data));
            br_bge:  cond_true = ($signed(rs1_data) >= $signed(rs2_data));
            br_bltu: cond_true = (rs1_data < rs2_data);
            br_bgeu: cond_true = (rs1_data >= rs2_data);
            default: cond_true = 1'b0;  // reserved funct3 never branches
        endcase
    end

    // target is the alu sum in every case
    always_comb begin
        jump_en     = 1'b0;
        jump_target = alu_result;
        case (opcode)
            opc_jal: jump_en = 1'b1;
            opc_jalr: begin
                jump_en     = 1'b1;
                jump_target = {alu_result[`RV_XLEN-1:1], 1'b0};  // rs1 + imm, bit 0 cleared
            end
            opc_branch: jump_en = cond_true;
            default: ;
        endcase
    end

endmodule

// File: rtl/pc_writeback.sv
/* program counter register, next-pc select and write-back data select */
`timescale 1ns/1ns
`include "rv_defines.svh"

module pc_writeback (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_ctrl_pkg::wb_src_e  wb_src,
    input  logic                  jump_en,
    input  logic [`RV_XLEN-1:0]   jump_target,
    input  logic [`RV_XLEN-1:0]   alu_result,
    output logic [`RV_XLEN-1:0]   pc,
    output logic                  wb_en,
    output logic [`RV_XLEN-1:0]   wb_data
);
    import rv_ctrl_pkg::*;

    localparam logic [`RV_XLEN-1:0] pc_step = 4;

    logic [`RV_XLEN-1:0] seq_pc;

    assign seq_pc = pc + pc_step;  // also the link address

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RV_RESET_PC;
        end else if (jump_en) begin
            pc <= jump_target;
        end else begin
            pc <= seq_pc;
        end
    end

    assign wb_data = (wb_src == wb_link) ? seq_pc : alu_result;

    // no retiring write while reset is asserted
    assign wb_en = (wb_src != wb_none) && !reset;

endmodule

// File: rtl/rv_core.sv
/* single-cycle rv32i core top: decoder, register file, alu, branch unit, pc and write-back */
`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_core (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`RV_XLEN-1:0]   inst,     // from external instruction memory
    output logic [`RV_XLEN-1:0]   pc,
    output logic                  wb_en,
    output logic [`RV_REG_AW-1:0] wb_rd,
    output logic [`RV_XLEN-1:0]   wb_data
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    opcode_e                opcode;
    alu_op_e                alu_op;
    branch_cond_e           branch_cond;
    wb_src_e                wb_src;
    logic [`RV_REG_AW-1:0]  rs1;
    logic [`RV_REG_AW-1:0]  rs2;
    logic [`RV_REG_AW-1:0]  rd;
    logic [`RV_XLEN-1:0]    imm;
    logic [`RV_XLEN-1:0]    rs1_data;
    logic [`RV_XLEN-1:0]    rs2_data;
    logic [`RV_XLEN-1:0]    alu_result;
    logic                   jump_en;
    logic [`RV_XLEN-1:0]    jump_target;

    assign wb_rd = rd;

    inst_decoder u_dec (
        .inst(inst), .opcode(opcode), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .alu_op(alu_op), .branch_cond(branch_cond), .wb_src(wb_src)
    );

    reg_file u_rf (
        .clk(clk), .reset(reset), .we(wb_en), .waddr(rd), .wdata(wb_data),
        .raddr1(rs1), .raddr2(rs2), .rdata1(rs1_data), .rdata2(rs2_data)
    );

    alu_exec u_alu (
        .opcode(opcode), .alu_op(alu_op), .pc(pc), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .imm(imm), .alu_result(alu_result)
    );

    branch_resolve u_br (
        .opcode(opcode), .branch_cond(branch_cond), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .alu_result(alu_result),
        .jump_en(jump_en), .jump_target(jump_target)
    );

    pc_writeback u_pcwb (
        .clk(clk), .reset(reset), .wb_src(wb_src), .jump_en(jump_en),
        .jump_target(jump_target), .alu_result(alu_result),
        .pc(pc), .wb_en(wb_en), .wb_data(wb_data)
    );

endmodule

// File: bench/rv_core_tb.sv
/* testbench for rv_core: clock, reset, instruction encoders, program table,
   checking loop and cycle timeout */
`timescale 1ns/1ns
`include "rv_defines.svh"

module rv_core_tb;

    localparam logic [`RV_XLEN-1:0] base = `RV_RESET_PC;

    logic                  clk;
    logic                  reset;
    logic [`RV_XLEN-1:0]   inst;
    logic [`RV_XLEN-1:0]   pc;
    logic                  wb_en;
    logic [`RV_REG_AW-1:0] wb_rd;
    logic [`RV_XLEN-1:0]   wb_data;

    // program table, one entry per executed instruction
    string       names[$];
    logic [31:0] insts[$];
    logic [31:0] exp_pc[$];
    logic        exp_en[$];
    logic [4:0]  exp_rd[$];
    logic [31:0] exp_data[$];

    int unsigned cycles;

    rv_core UUT (
        .clk(clk), .reset(reset), .inst(inst),
        .pc(pc), .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // instruction encoders, fields in ISA order
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic add_row(input string name, input logic [31:0] word, input logic [31:0] epc,
                           input logic en, input logic [4:0] rd, input logic [31:0] data);
        names.push_back(name);
        insts.push_back(word);
        exp_pc.push_back(epc);
        exp_en.push_back(en);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s %s: expected %h, actual %h", name, field, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic build_program();
        add_row("addi_pos",  enc_i(12'd5, 5'd0, 3'b000, 5'd1, 7'h13),   base,         1, 1, 5);
        add_row("addi_neg",  enc_i(12'hffd, 5'd0, 3'b000, 5'd2, 7'h13), base + 'h04,  1, 2,
                32'hffff_fffd);
        add_row("add",       enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3),   base + 'h08,  1, 3, 2);
        add_row("sub",       enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4),   base + 'h0c,  1, 4, 8);
        add_row("slt",       enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd5),   base + 'h10,  1, 5, 1);
        add_row("sltu",      enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd6),   base + 'h14,  1, 6, 0);
        add_row("and",       enc_r(7'h00, 5'd4, 5'd2, 3'b111, 5'd7),   base + 'h18,  1, 7, 8);
        add_row("or",        enc_r(7'h00, 5'd4, 5'd1, 3'b110, 5'd8),   base + 'h1c,  1, 8, 'hd);
        add_row("xor",       enc_r(7'h00, 5'd1, 5'd2, 3'b100, 5'd9),   base + 'h20,  1, 9,
                32'hffff_fff8);
        add_row("andi",      enc_i(12'h0f0, 5'd2, 3'b111, 5'd10, 7'h13), base + 'h24, 1, 10,
                'hf0);
        add_row("ori",       enc_i(12'h100, 5'd1, 3'b110, 5'd11, 7'h13), base + 'h28, 1, 11,
                'h105);
        add_row("xori",      enc_i(12'hfff, 5'd1, 3'b100, 5'd12, 7'h13), base + 'h2c, 1, 12,
                32'hffff_fffa);
        add_row("sll",       enc_r(7'h00, 5'd1, 5'd1, 3'b001, 5'd13),  base + 'h30,  1, 13, 'ha0);
        add_row("srl",       enc_r(7'h00, 5'd1, 5'd2, 3'b101, 5'd14),  base + 'h34,  1, 14,
                32'h07ff_ffff);
        add_row("sra",       enc_r(7'h20, 5'd1, 5'd2, 3'b101, 5'd15),  base + 'h38,  1, 15,
                32'hffff_ffff);
        add_row("srai",      enc_i(12'h401, 5'd2, 3'b101, 5'd16, 7'h13), base + 'h3c, 1, 16,
                32'hffff_fffe);
        add_row("slli",      enc_i(12'h004, 5'd1, 3'b001, 5'd17, 7'h13), base + 'h40, 1, 17,
                'h50);
        add_row("lui",       enc_u(20'h12345, 5'd18, 7'h37),           base + 'h44,  1, 18,
                32'h1234_5000);
        add_row("auipc",     enc_u(20'h00001, 5'd19, 7'h17),           base + 'h48,  1, 19,
                32'h8000_1048);
        add_row("beq_taken", enc_b(13'd8, 5'd1, 5'd1, 3'b000),         base + 'h4c,  0, 0, 0);
        add_row("blt_taken", enc_b(13'd12, 5'd1, 5'd2, 3'b100),        base + 'h54,  0, 0, 0);
        add_row("bne_not",   enc_b(13'd16, 5'd1, 5'd1, 3'b001),        base + 'h60,  0, 0, 0);
        add_row("bgeu_not",  enc_b(13'd16, 5'd2, 5'd1, 3'b111),        base + 'h64,  0, 0, 0);
        add_row("jal",       enc_j(21'd16, 5'd20),                     base + 'h68,  1, 20,
                32'h8000_006c);
        add_row("auipc_0",   enc_u(20'h00000, 5'd21, 7'h17),           base + 'h78,  1, 21,
                32'h8000_0078);
        add_row("jalr",      enc_i(12'h015, 5'd21, 3'b000, 5'd22, 7'h67), base + 'h7c, 1, 22,
                32'h8000_0080);  // target 0x8d, bit 0 cleared
        add_row("addi_x0",   enc_i(12'd7, 5'd1, 3'b000, 5'd0, 7'h13),  base + 'h8c,  1, 0, 'hc);
        add_row("add_x0",    enc_r(7'h00, 5'd2, 5'd0, 3'b000, 5'd23),  base + 'h90,  1, 23,
                32'hffff_fffd);
        add_row("add_back",  enc_r(7'h00, 5'd13, 5'd3, 3'b000, 5'd24), base + 'h94,  1, 24, 'ha2);
        add_row("fence_nop", 32'h0000_000f,                            base + 'h98,  0, 0, 0);
        add_row("addi_zero", enc_i(12'hf5e, 5'd24, 3'b000, 5'd25, 7'h13), base + 'h9c, 1, 25, 0);
    endtask

    // run limit from table length plus reset and margin
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > names.size() + 3 + 10) begin
            $display("timeout: the run went past %0d clock cycles", cycles);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    initial begin
        cycles = 0;
        reset  = 1'b1;
        inst   = enc_i(12'd1, 5'd0, 3'b000, 5'd1, 7'h13);  // addi, must not retire in reset
        build_program();

        for (int c = 0; c < 3; c++) begin
            @(negedge clk);
            check_value("reset", "wb_en", 32'd0, {31'b0, wb_en});
            check_value("reset", "pc", base, pc);
        end

        for (int i = 0; i < names.size(); i++) begin
            @(posedge clk);
            reset <= 1'b0;
            inst  <= insts[i];
            @(negedge clk);  // outputs settled mid-cycle
            check_value(names[i], "pc", exp_pc[i], pc);
            check_value(names[i], "wb_en", {31'b0, exp_en[i]}, {31'b0, wb_en});
            if (exp_en[i]) begin
                check_value(names[i], "wb_rd", {27'b0, exp_rd[i]}, {27'b0, wb_rd});
                check_value(names[i], "wb_data", exp_data[i], wb_data);
            end
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
rtl/rv_isa_pkg.sv
rtl/rv_ctrl_pkg.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/alu_exec.sv
rtl/branch_resolve.sv
rtl/pc_writeback.sv
rtl/rv_core.sv
bench/rv_core_tb.sv
